/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rename_core
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTS PASSED" $(LOG); then echo "No pass result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alloc.sv */
`timescale 1ns/1ps

module alloc (
   input  logic                          clk,
   input  logic                          rst_n,
   input  instr_pkg::t_uinstr            uinstr_ra0,
   input  core_pkg::t_rob_id             next_robid_ra0,
   input  logic                          rob_ready_ra0,
   output instr_pkg::t_rv_reg_addr [1:0] src_addr_ra0,
   input  core_pkg::t_rob_id [1:0]       rob_src_reg_robid_ra0,
   input  logic [1:0]                    rob_src_reg_pdg_ra0,
   output logic                          alloc_ready_ra0,
   output logic                          alloc_ra0,
   input  logic                          port_stall_ra1,
   output logic                          disp_valid_ra1,
   output core_pkg::t_uinstr_disp        disp_ra1
);

   core_pkg::t_rename_pkt  rename_ra0;
   core_pkg::t_uinstr_disp disp_ra0;
   logic                   valid_ra1_q;

   // Table lookups for both sources
   assign src_addr_ra0 = {uinstr_ra0.src2, uinstr_ra0.src1};

   always_comb begin
      rename_ra0.pdst     = next_robid_ra0;
      rename_ra0.psrc1    = rob_src_reg_robid_ra0[0];
      rename_ra0.psrc2    = rob_src_reg_robid_ra0[1];
      // Unused operands never wait
      rename_ra0.src1_pdg = rob_src_reg_pdg_ra0[0] & uinstr_ra0.src1_use;
      rename_ra0.src2_pdg = rob_src_reg_pdg_ra0[1] & uinstr_ra0.src2_use;
   end

   always_comb begin
      disp_ra0.uinstr = uinstr_ra0;
      disp_ra0.robid  = next_robid_ra0;
      disp_ra0.rename = rename_ra0;
   end

   // Accept only with a free ROB id and a moving ra1
   assign alloc_ready_ra0 = rob_ready_ra0 & ~port_stall_ra1;
   assign alloc_ra0       = uinstr_ra0.valid & alloc_ready_ra0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_ra1_q <= 1'b0;
      end else if (alloc_ra0) begin
         valid_ra1_q <= 1'b1;
      end else if (!port_stall_ra1) begin
         // Held op left and nothing replaced it
         valid_ra1_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (alloc_ra0) begin
         disp_ra1 <= disp_ra0;
      end
   end

   assign disp_valid_ra1 = valid_ra1_q;

endmodule

/* build.f */
instr_pkg.sv
core_pkg.sv
uop_decode.sv
rename_table.sv
rob_tracker.sv
alloc.sv
dispatch_router.sv
rename_core.sv
rename_core_properties.sv
tb_rename_core.sv

/* core_pkg.sv */
package core_pkg;

   // ROB id width, so at most 32 entries in flight
   localparam int ROB_ID_W = 5;

   typedef logic [ROB_ID_W-1:0] t_rob_id;

   // Result of renaming one micro-op
   typedef struct packed {
      t_rob_id pdst;
      t_rob_id psrc1;
      t_rob_id psrc2;
      logic    src1_pdg;
      logic    src2_pdg;
   } t_rename_pkt;

   // Everything a reservation station needs from rename
   typedef struct packed {
      instr_pkg::t_uinstr uinstr;
      t_rob_id            robid;
      t_rename_pkt        rename;
   } t_uinstr_disp;

   localparam int NUM_DISP_PORTS = 2;

   typedef enum logic [$clog2(NUM_DISP_PORTS)-1:0] {
      DISP_PORT_EINT,
      DISP_PORT_MEM
   } t_disp_port;

endpackage

/* dispatch_router.sv */
`timescale 1ns/1ps

module dispatch_router (
   input  logic                   disp_valid_ra1,
   input  core_pkg::t_uinstr_disp disp_ra1,
   input  logic                   eint_stall,
   input  logic                   mem_stall,
   output logic                   port_stall_ra1,
   output logic                   disp_valid_eint,
   output core_pkg::t_uinstr_disp disp_eint,
   output logic                   disp_valid_mem,
   output core_pkg::t_uinstr_disp disp_mem
);

   core_pkg::t_disp_port                target_port;
   logic [core_pkg::NUM_DISP_PORTS-1:0] stall_ports;
   logic [core_pkg::NUM_DISP_PORTS-1:0] valid_ports;

   // Memory ops to the memory port, everything else to integer
   always_comb begin
      case (disp_ra1.uinstr.uop_class)
         instr_pkg::LOAD,
         instr_pkg::STORE: target_port = core_pkg::DISP_PORT_MEM;
         default:          target_port = core_pkg::DISP_PORT_EINT;
      endcase
   end

   assign stall_ports[core_pkg::DISP_PORT_EINT] = eint_stall;
   assign stall_ports[core_pkg::DISP_PORT_MEM]  = mem_stall;

   // Only the targeted port can hold up ra1
   assign port_stall_ra1 = disp_valid_ra1 & stall_ports[target_port];

   always_comb begin
      for (int p = 0; p < core_pkg::NUM_DISP_PORTS; p++) begin
         valid_ports[p] = disp_valid_ra1 && (int'(target_port) == p) && !stall_ports[p];
      end
   end

   assign disp_valid_eint = valid_ports[core_pkg::DISP_PORT_EINT];
   assign disp_eint       = disp_ra1;
   assign disp_valid_mem  = valid_ports[core_pkg::DISP_PORT_MEM];
   assign disp_mem        = disp_ra1;

endmodule

/* instr_pkg.sv */
package instr_pkg;

   // Architectural register index, x0 to x31
   typedef logic [4:0] t_rv_reg_addr;

   // Major opcodes handled by this slice
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;

   // Register-register layout, MSB first
   typedef struct packed {
      logic [6:0]   funct7;
      t_rv_reg_addr rs2;
      t_rv_reg_addr rs1;
      logic [2:0]   funct3;
      t_rv_reg_addr rd;
      logic [6:0]   opcode;
   } t_rtype_fmt;

   // Immediate layout, shares the low 20 bits with the R view
   typedef struct packed {
      logic [11:0]  imm;
      t_rv_reg_addr rs1;
      logic [2:0]   funct3;
      t_rv_reg_addr rd;
      logic [6:0]   opcode;
   } t_itype_fmt;

   typedef union packed {
      t_rtype_fmt r;
      t_itype_fmt i;
   } t_instr_word;

   typedef enum logic [1:0] {
      ALU,
      LOAD,
      STORE
   } t_uop_class;

   // Decoded micro-op as seen by rename
   typedef struct packed {
      logic         valid;
      t_uop_class   uop_class;
      t_rv_reg_addr src1;
      logic         src1_use;
      t_rv_reg_addr src2;
      logic         src2_use;
      t_rv_reg_addr dst;
      logic         dst_wr;
      logic [11:0]  imm;
      logic [15:0]  simid;
   } t_uinstr;

endpackage

/* rename_core.sv */
`timescale 1ns/1ps

module rename_core #(
   parameter int ROB_DEPTH = 16
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   instr_valid,
   input  instr_pkg::t_instr_word instr_word,
   output logic                   instr_ready,
   input  logic                   wb_valid,
   input  core_pkg::t_rob_id      wb_robid,
   input  logic                   retire_valid,
   input  logic                   eint_stall,
   input  logic                   mem_stall,
   output logic                   disp_valid_eint,
   output core_pkg::t_uinstr_disp disp_eint,
   output logic                   disp_valid_mem,
   output core_pkg::t_uinstr_disp disp_mem
);

   instr_pkg::t_uinstr            uinstr_ra0;
   instr_pkg::t_rv_reg_addr [1:0] src_addr_ra0;
   core_pkg::t_rob_id [1:0]       src_robid_ra0;
   logic [1:0]                    src_pdg_ra0;
   core_pkg::t_rob_id             next_robid_ra0;
   logic                          rob_ready_ra0;
   logic                          alloc_ready_ra0;
   logic                          alloc_ra0;
   logic                          port_stall_ra1;
   logic                          disp_valid_ra1;
   core_pkg::t_uinstr_disp        disp_ra1;

   assign instr_ready = alloc_ready_ra0;

   uop_decode u_uop_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr_word  (instr_word),
      .uinstr_ra0  (uinstr_ra0)
   );

   rename_table u_rename_table (
      .clk       (clk),
      .rst_n     (rst_n),
      .src_addr  (src_addr_ra0),
      .src_robid (src_robid_ra0),
      .src_pdg   (src_pdg_ra0),
      .alloc     (alloc_ra0),
      .dst_addr  (uinstr_ra0.dst),
      .dst_wr    (uinstr_ra0.dst_wr),
      .dst_robid (next_robid_ra0),
      .wb_valid  (wb_valid),
      .wb_robid  (wb_robid)
   );

   rob_tracker #(
      .ROB_DEPTH (ROB_DEPTH)
   ) u_rob_tracker (
      .clk          (clk),
      .rst_n        (rst_n),
      .alloc        (alloc_ra0),
      .retire_valid (retire_valid),
      .next_robid   (next_robid_ra0),
      .rob_ready    (rob_ready_ra0)
   );

   alloc u_alloc (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .uinstr_ra0            (uinstr_ra0),
      .next_robid_ra0        (next_robid_ra0),
      .rob_ready_ra0         (rob_ready_ra0),
      .src_addr_ra0          (src_addr_ra0),
      .rob_src_reg_robid_ra0 (src_robid_ra0),
      .rob_src_reg_pdg_ra0   (src_pdg_ra0),
      .alloc_ready_ra0       (alloc_ready_ra0),
      .alloc_ra0             (alloc_ra0),
      .port_stall_ra1        (port_stall_ra1),
      .disp_valid_ra1        (disp_valid_ra1),
      .disp_ra1              (disp_ra1)
   );

   dispatch_router u_dispatch_router (
      .disp_valid_ra1  (disp_valid_ra1),
      .disp_ra1        (disp_ra1),
      .eint_stall      (eint_stall),
      .mem_stall       (mem_stall),
      .port_stall_ra1  (port_stall_ra1),
      .disp_valid_eint (disp_valid_eint),
      .disp_eint       (disp_eint),
      .disp_valid_mem  (disp_valid_mem),
      .disp_mem        (disp_mem)
   );

endmodule

/* rename_core_properties.sv */
`timescale 1ns/1ps

module rename_core_properties #(
   parameter int ROB_DEPTH = 16
) (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   instr_valid,
   input logic                   instr_ready,
   input logic                   retire_valid,
   input logic                   eint_stall,
   input logic                   mem_stall,
   input logic                   disp_valid_eint,
   input logic                   disp_valid_mem,
   input logic                   disp_valid_ra1,
   input core_pkg::t_uinstr_disp disp_ra1
);

   int unsigned       error_count = 0;
   logic [5:0]        rob_count_q;
   core_pkg::t_rob_id exp_robid_q;
   logic              accept;
   logic              to_mem;
   logic              stall_tgt;

   assign accept    = instr_valid & instr_ready;
   assign to_mem    = disp_ra1.uinstr.uop_class != instr_pkg::ALU;
   assign stall_tgt = disp_valid_ra1 & (to_mem ? mem_stall : eint_stall);

   // Occupancy seen from the handshake and retire pins
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rob_count_q <= '0;
      end else begin
         rob_count_q <= rob_count_q + 6'(accept) - 6'(retire_valid && rob_count_q != '0);
      end
   end

   // Id the next accepted op should take
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         exp_robid_q <= '0;
      end else if (accept) begin
         exp_robid_q <= core_pkg::t_rob_id'((int'(exp_robid_q) + 1) % ROB_DEPTH);
      end
   end

   a_reset_state: assert property (@(posedge clk)
      $rose(rst_n) |-> !disp_valid_eint && !disp_valid_mem && instr_ready)
      else begin $error("Outputs not idle after reset"); error_count++; end

   a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      accept |=> disp_valid_ra1)
      else begin $error("Accepted op missing from ra1"); error_count++; end

   // Other port's stall must not matter
   a_route: assert property (@(posedge clk) disable iff (!rst_n)
      disp_valid_ra1 && !stall_tgt |->
         (to_mem ? (disp_valid_mem && !disp_valid_eint) : (disp_valid_eint && !disp_valid_mem)))
      else begin $error("Op not sent to its class port"); error_count++; end

   a_robid_order: assert property (@(posedge clk) disable iff (!rst_n)
      accept |=> disp_ra1.robid == $past(exp_robid_q))
      else begin $error("ROB id out of allocation order"); error_count++; end

   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      stall_tgt |=> disp_valid_ra1 && $stable(disp_ra1))
      else begin $error("ra1 changed under stall"); error_count++; end

   a_stall_block: assert property (@(posedge clk) disable iff (!rst_n)
      stall_tgt |-> !instr_ready && !disp_valid_eint && !disp_valid_mem)
      else begin $error("Stall did not block"); error_count++; end

   a_rob_full: assert property (@(posedge clk) disable iff (!rst_n)
      rob_count_q == ROB_DEPTH |-> !instr_ready)
      else begin $error("Ready while ROB full"); error_count++; end

   a_rob_free: assert property (@(posedge clk) disable iff (!rst_n)
      rob_count_q < ROB_DEPTH && !stall_tgt |-> instr_ready)
      else begin $error("Not ready with free ROB entries"); error_count++; end

endmodule

bind rename_core rename_core_properties #(.ROB_DEPTH(ROB_DEPTH)) u_props (
   .clk             (clk),
   .rst_n           (rst_n),
   .instr_valid     (instr_valid),
   .instr_ready     (instr_ready),
   .retire_valid    (retire_valid),
   .eint_stall      (eint_stall),
   .mem_stall       (mem_stall),
   .disp_valid_eint (disp_valid_eint),
   .disp_valid_mem  (disp_valid_mem),
   .disp_valid_ra1  (disp_valid_ra1),
   .disp_ra1        (disp_ra1)
);

/* rename_table.sv */
`timescale 1ns/1ps

module rename_table (
   input  logic                          clk,
   input  logic                          rst_n,
   input  instr_pkg::t_rv_reg_addr [1:0] src_addr,
   output core_pkg::t_rob_id [1:0]       src_robid,
   output logic [1:0]                    src_pdg,
   input  logic                          alloc,
   input  instr_pkg::t_rv_reg_addr       dst_addr,
   input  logic                          dst_wr,
   input  core_pkg::t_rob_id             dst_robid,
   input  logic                          wb_valid,
   input  core_pkg::t_rob_id             wb_robid
);

   localparam int NUM_ARCH_REGS = 32;

   core_pkg::t_rob_id        prod_robid [NUM_ARCH_REGS];
   logic [NUM_ARCH_REGS-1:0] mapped_q;
   logic [NUM_ARCH_REGS-1:0] pdg_q;
   logic [NUM_ARCH_REGS-1:0] wb_hit;
   logic                     dst_upd;

   assign dst_upd = alloc & dst_wr;

   // Every entry waiting on the written-back producer
   always_comb begin
      for (int r = 0; r < NUM_ARCH_REGS; r++) begin
         wb_hit[r] = wb_valid && (prod_robid[r] == wb_robid);
      end
   end

   always_comb begin
      for (int s = 0; s < 2; s++) begin
         src_robid[s] = mapped_q[src_addr[s]] ? prod_robid[src_addr[s]] : '0;
         // A writeback in the same cycle already counts as done
         src_pdg[s]   = mapped_q[src_addr[s]] & pdg_q[src_addr[s]] & ~wb_hit[src_addr[s]];
      end
   end

   always_ff @(posedge clk) begin
      if (dst_upd) begin
         prod_robid[dst_addr] <= dst_robid;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mapped_q <= '0;
         pdg_q    <= '0;
      end else begin
         pdg_q <= pdg_q & ~wb_hit;
         // New producer overrides a writeback to the same register
         if (dst_upd) begin
            mapped_q[dst_addr] <= 1'b1;
            pdg_q[dst_addr]    <= 1'b1;
         end
      end
   end

endmodule

/* rob_tracker.sv */
`timescale 1ns/1ps

module rob_tracker #(
   parameter int ROB_DEPTH = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              alloc,
   input  logic              retire_valid,
   output core_pkg::t_rob_id next_robid,
   output logic              rob_ready
);

   localparam int IDX_W = $clog2(ROB_DEPTH);

   // Extra wrap bit tells full from empty
   logic [IDX_W:0] head_q;
   logic [IDX_W:0] tail_q;
   logic [IDX_W:0] count;
   logic           alloc_ok;
   logic           retire_ok;

   assign count     = tail_q - head_q;
   assign rob_ready = count < (IDX_W+1)'(ROB_DEPTH);

   assign alloc_ok  = alloc & rob_ready;
   // Retire on an empty ROB is dropped
   assign retire_ok = retire_valid & (count != '0);

   assign next_robid = core_pkg::t_rob_id'(tail_q[IDX_W-1:0]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         head_q <= '0;
         tail_q <= '0;
      end else begin
         if (alloc_ok) begin
            tail_q <= tail_q + 1'b1;
         end
         if (retire_ok) begin
            head_q <= head_q + 1'b1;
         end
      end
   end

endmodule

/* tb_rename_core.sv */
`timescale 1ns/1ps

module tb_rename_core;

   localparam int ROB_DEPTH = 8;

   logic                   clk;
   logic                   rst_n;
   logic                   instr_valid;
   instr_pkg::t_instr_word instr_word;
   logic                   instr_ready;
   logic                   wb_valid;
   core_pkg::t_rob_id      wb_robid;
   logic                   retire_valid;
   logic                   eint_stall;
   logic                   mem_stall;
   logic                   disp_valid_eint;
   core_pkg::t_uinstr_disp disp_eint;
   logic                   disp_valid_mem;
   core_pkg::t_uinstr_disp disp_mem;

   // Reference model of the alias table and ROB order
   logic                   map_valid [32];
   core_pkg::t_rob_id      map_robid [32];
   logic                   map_pdg [32];
   core_pkg::t_uinstr_disp sb_queue [$];
   int                     next_id;
   int                     in_flight;
   logic [31:0]            lfsr = 32'hda3b_992a;

   rename_core #(
      .ROB_DEPTH (ROB_DEPTH)
   ) UUT (
      .clk             (clk),
      .rst_n           (rst_n),
      .instr_valid     (instr_valid),
      .instr_word      (instr_word),
      .instr_ready     (instr_ready),
      .wb_valid        (wb_valid),
      .wb_robid        (wb_robid),
      .retire_valid    (retire_valid),
      .eint_stall      (eint_stall),
      .mem_stall       (mem_stall),
      .disp_valid_eint (disp_valid_eint),
      .disp_eint       (disp_eint),
      .disp_valid_mem  (disp_valid_mem),
      .disp_mem        (disp_mem)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run();
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("FAILED at time %0t: %s = %0h, expected %0h", $time, name, got, exp);
         abort_run();
      end
   endtask

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Registers x0 to x7 only so that dependencies and x0 show up often
   function automatic instr_pkg::t_instr_word make_word();
      logic [31:0] w;
      logic [1:0]  kind;
      kind       = 2'(rand_bits(2));
      w[31:25]   = 7'(rand_bits(7));
      w[24:20]   = 5'(rand_bits(3));
      w[19:15]   = 5'(rand_bits(3));
      w[14:12]   = 3'b000;
      w[11:7]    = 5'(rand_bits(3));
      case (kind)
         2'd0:    w[6:0] = instr_pkg::OPC_OP;
         2'd1:    w[6:0] = instr_pkg::OPC_OP_IMM;
         2'd2:    w[6:0] = instr_pkg::OPC_LOAD;
         default: w[6:0] = instr_pkg::OPC_STORE;
      endcase
      return w;
   endfunction

   task automatic record_alloc();
      core_pkg::t_uinstr_disp  e;
      instr_pkg::t_rv_reg_addr s1;
      instr_pkg::t_rv_reg_addr s2;
      logic [6:0]              opc;
      logic [31:0]             w;
      w   = instr_word;
      opc = instr_word.r.opcode;
      e   = '0;
      // I-type offset sits in the top 12 bits, S-type splits it around rs2
      if (opc == instr_pkg::OPC_LOAD) begin
         e.uinstr.uop_class = instr_pkg::LOAD;
         e.uinstr.imm       = w[31:20];
      end else if (opc == instr_pkg::OPC_STORE) begin
         e.uinstr.uop_class = instr_pkg::STORE;
         e.uinstr.imm       = {w[31:25], w[11:7]};
      end else begin
         e.uinstr.uop_class = instr_pkg::ALU;
         if (opc == instr_pkg::OPC_OP_IMM) begin
            e.uinstr.imm = w[31:20];
         end
      end
      e.uinstr.src1_use = instr_word.r.rs1 != '0;
      e.uinstr.src2_use = (opc == instr_pkg::OPC_OP || opc == instr_pkg::OPC_STORE) &&
                          instr_word.r.rs2 != '0;
      e.uinstr.dst_wr   = opc != instr_pkg::OPC_STORE && instr_word.r.rd != '0;
      s1 = e.uinstr.src1_use ? instr_word.r.rs1 : '0;
      s2 = e.uinstr.src2_use ? instr_word.r.rs2 : '0;
      e.uinstr.src1     = s1;
      e.uinstr.src2     = s2;
      e.uinstr.dst      = instr_word.r.rd;
      e.robid           = core_pkg::t_rob_id'(next_id);
      e.rename.pdst     = core_pkg::t_rob_id'(next_id);
      e.rename.psrc1    = map_valid[s1] ? map_robid[s1] : '0;
      e.rename.psrc2    = map_valid[s2] ? map_robid[s2] : '0;
      e.rename.src1_pdg = e.uinstr.src1_use & map_valid[s1] & map_pdg[s1];
      e.rename.src2_pdg = e.uinstr.src2_use & map_valid[s2] & map_pdg[s2];
      sb_queue.push_back(e);
      // New producer wins over a writeback in the same cycle
      if (e.uinstr.dst_wr) begin
         map_valid[instr_word.r.rd] = 1'b1;
         map_robid[instr_word.r.rd] = core_pkg::t_rob_id'(next_id);
         map_pdg[instr_word.r.rd]   = 1'b1;
      end
      next_id   = (next_id + 1) % ROB_DEPTH;
      in_flight = in_flight + 1;
   endtask

   task automatic check_dispatch();
      core_pkg::t_uinstr_disp e;
      core_pkg::t_uinstr_disp g;
      logic                   to_mem;
      if (sb_queue.size() == 0) begin
         $display("Dispatch seen with no accepted micro-op outstanding");
         abort_run();
      end
      e      = sb_queue.pop_front();
      to_mem = e.uinstr.uop_class != instr_pkg::ALU;
      g      = to_mem ? disp_mem : disp_eint;
      check_value("disp_valid_mem", disp_valid_mem, to_mem);
      check_value("disp_valid_eint", disp_valid_eint, !to_mem);
      check_value("uop_class", g.uinstr.uop_class, e.uinstr.uop_class);
      check_value("src1_use", g.uinstr.src1_use, e.uinstr.src1_use);
      check_value("src2_use", g.uinstr.src2_use, e.uinstr.src2_use);
      check_value("dst_wr", g.uinstr.dst_wr, e.uinstr.dst_wr);
      if (e.uinstr.src1_use) begin
         check_value("src1", g.uinstr.src1, e.uinstr.src1);
      end
      if (e.uinstr.src2_use) begin
         check_value("src2", g.uinstr.src2, e.uinstr.src2);
      end
      if (e.uinstr.dst_wr) begin
         check_value("dst", g.uinstr.dst, e.uinstr.dst);
      end
      check_value("imm", g.uinstr.imm, e.uinstr.imm);
      check_value("robid", g.robid, e.robid);
      check_value("pdst", g.rename.pdst, e.rename.pdst);
      check_value("psrc1", g.rename.psrc1, e.rename.psrc1);
      check_value("psrc2", g.rename.psrc2, e.rename.psrc2);
      check_value("src1_pdg", g.rename.src1_pdg, e.rename.src1_pdg);
      check_value("src2_pdg", g.rename.src2_pdg, e.rename.src2_pdg);
   endtask

   // Model steps at the falling edge where inputs are stable
   always @(negedge clk) begin
      if (rst_n) begin
         if (wb_valid) begin
            for (int r = 0; r < 32; r++) begin
               if (map_robid[r] == wb_robid) begin
                  map_pdg[r] = 1'b0;
               end
            end
         end
         if (disp_valid_eint || disp_valid_mem) begin
            check_dispatch();
         end
         // Retire on an empty ROB is ignored
         if (retire_valid && in_flight != 0) begin
            in_flight = in_flight - 1;
         end
         if (instr_valid && instr_ready) begin
            record_alloc();
         end
      end
   end

   always @(negedge clk) begin
      if (UUT.u_props.error_count != 0) begin
         $display("A protocol assertion failed");
         abort_run();
      end
   end

   initial begin
      logic took;
      int   waited;
      rst_n        = 1'b0;
      instr_valid  = 1'b0;
      instr_word   = '0;
      wb_valid     = 1'b0;
      wb_robid     = '0;
      retire_valid = 1'b0;
      eint_stall   = 1'b0;
      mem_stall    = 1'b0;
      next_id      = 0;
      in_flight    = 0;
      for (int r = 0; r < 32; r++) begin
         map_valid[r] = 1'b0;
         map_robid[r] = '0;
         map_pdg[r]   = 1'b0;
      end
      repeat (4) @(posedge clk);
      #1 rst_n = 1'b1;

      // Random traffic with stalls, writebacks and retires
      for (int c = 0; c < 400; c++) begin
         @(negedge clk);
         took = instr_valid && instr_ready;
         @(posedge clk);
         #1;
         if (took || !instr_valid) begin
            instr_valid = rand_bits(2) != 0;
            instr_word  = make_word();
         end
         eint_stall   = rand_bits(2) == 3;
         mem_stall    = rand_bits(2) == 3;
         wb_valid     = rand_bits(1) != 0;
         wb_robid     = core_pkg::t_rob_id'(rand_bits(3));
         retire_valid = rand_bits(1) != 0;
      end

      // Fill the ROB with retire held off
      @(posedge clk);
      #1;
      eint_stall   = 1'b0;
      mem_stall    = 1'b0;
      wb_valid     = 1'b0;
      retire_valid = 1'b0;
      instr_valid  = 1'b1;
      instr_word   = make_word();
      waited       = 0;
      @(negedge clk);
      while (instr_ready) begin
         waited++;
         if (waited > 4 * ROB_DEPTH) begin
            $display("Timeout: instr_ready never dropped with retire held off");
            abort_run();
         end
         @(posedge clk);
         #1 instr_word = make_word();
         @(negedge clk);
      end
      check_value("rob_count", in_flight, ROB_DEPTH);

      // One retire frees exactly one slot
      @(posedge clk);
      #1 retire_valid = 1'b1;
      @(posedge clk);
      #1 retire_valid = 1'b0;
      @(negedge clk);
      check_value("instr_ready", instr_ready, 1'b1);
      @(posedge clk);
      #1 instr_word = make_word();
      @(negedge clk);
      check_value("instr_ready", instr_ready, 1'b0);
      @(posedge clk);
      #1 instr_valid = 1'b0;

      waited = 0;
      while (sb_queue.size() != 0) begin
         waited++;
         if (waited > 50) begin
            $display("Timeout: accepted micro-ops never dispatched");
            abort_run();
         end
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      @(negedge clk);

      if (UUT.u_props.error_count != 0) begin
         $display("A protocol assertion failed");
         abort_run();
      end else begin
         $display("TESTS PASSED");
         $finish;
      end
   end

endmodule

/* uop_decode.sv */
`timescale 1ns/1ps

module uop_decode (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   instr_valid,
   input  instr_pkg::t_instr_word instr_word,
   output instr_pkg::t_uinstr     uinstr_ra0
);

   logic [15:0] simid_q;

   // Running tag, one step per presented word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         simid_q <= '0;
      end else if (instr_valid) begin
         simid_q <= simid_q + 16'd1;
      end
   end

   always_comb begin
      uinstr_ra0           = '0;
      uinstr_ra0.valid     = instr_valid;
      uinstr_ra0.simid     = simid_q;
      uinstr_ra0.uop_class = instr_pkg::ALU;
      uinstr_ra0.src1      = instr_word.r.rs1;
      uinstr_ra0.src2      = instr_word.r.rs2;
      uinstr_ra0.dst       = instr_word.r.rd;

      case (instr_word.r.opcode)
         instr_pkg::OPC_OP: begin
            uinstr_ra0.src1_use = 1'b1;
            uinstr_ra0.src2_use = 1'b1;
            uinstr_ra0.dst_wr   = 1'b1;
         end
         instr_pkg::OPC_OP_IMM: begin
            uinstr_ra0.src1_use = 1'b1;
            uinstr_ra0.dst_wr   = 1'b1;
            uinstr_ra0.imm      = instr_word.i.imm;
         end
         instr_pkg::OPC_LOAD: begin
            uinstr_ra0.uop_class = instr_pkg::LOAD;
            uinstr_ra0.src1_use  = 1'b1;
            uinstr_ra0.dst_wr    = 1'b1;
            uinstr_ra0.imm       = instr_word.i.imm;
         end
         instr_pkg::OPC_STORE: begin
            // S-type splits the offset around rs2
            uinstr_ra0.uop_class = instr_pkg::STORE;
            uinstr_ra0.src1_use  = 1'b1;
            uinstr_ra0.src2_use  = 1'b1;
            uinstr_ra0.imm       = {instr_word.r.funct7, instr_word.r.rd};
         end
         default: begin
            // Unknown opcodes go through as a nop on the integer port
         end
      endcase

      // x0 never carries a dependency
      if (uinstr_ra0.src1 == '0) begin
         uinstr_ra0.src1_use = 1'b0;
      end
      if (uinstr_ra0.src2 == '0) begin
         uinstr_ra0.src2_use = 1'b0;
      end
      if (uinstr_ra0.dst == '0) begin
         uinstr_ra0.dst_wr = 1'b0;
      end

      // Clean up fields that carry no operand
      if (!uinstr_ra0.src1_use) begin
         uinstr_ra0.src1 = '0;
      end
      if (!uinstr_ra0.src2_use) begin
         uinstr_ra0.src2 = '0;
      end
      if (!uinstr_ra0.dst_wr) begin
         uinstr_ra0.dst = '0;
      end
   end

endmodule
